//--- vlog.f
+incdir+include
source/board_pkg.sv
source/board_evt_if.sv
source/board_in_sync.sv
source/reset_sequencer.sv
source/activity_dimmer.sv
source/board_rst_top.sv
test/board_rst_chk.sv
test/board_rst_tb.sv

//--- Makefile
TOP = board_rst_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f vlog.f -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q -F '*** PASSED ***' sim.log

clean:
	rm -rf obj_dir sim.log

//--- test/board_rst_tb.sv
// Testbench for the board reset and activity logic.
// Drives random requests, lock loss and SD traffic into the top level and
// compares every output each cycle with a model of the latency rules.
// Prints one line per test, a count line and the verdict.

`timescale 1ns/1ps

module board_rst_tb;

	localparam int CYCLE_LIMIT = 120000;

	logic clk100mhz_i, rst_p, pll_locked_i;
	logic dev_rst0_i, dev_rst1_i, core_rst_i;
	logic sd_di_i, sd_do_i, dram_err_i;
	logic sys_rst_o, ram_rst_o, activity_o;

	// Model registers, evt_hist holds the port events of the last two edges.
	logic [1:0] m_pll, m_lines, evt_hist;
	logic m_core, m_pwr, m_sys, m_ram, m_act;
	int m_sys_cnt, m_ram_cnt, m_dark;

	integer seed;
	logic check_on;
	int since_pulse, pulses, cycles, errors, tests, test_start;

	board_rst_top dut (.*);

	initial begin
		clk100mhz_i = 1'b0;
		forever #5 clk100mhz_i = ~clk100mhz_i;
	end

	// Line 1 means warm or cold, both lines cold, line 0 alone power-off.
	always @(posedge clk100mhz_i) begin
		if (rst_p) begin
			{m_pll, m_lines, evt_hist} <= 6'b0;
			{m_core, m_pwr, m_act} <= 3'b000;
			{m_sys, m_ram} <= 2'b11;
			m_sys_cnt <= 4095;
			m_ram_cnt <= 4095;
			m_dark <= 0;
		end else begin
			m_pll <= {m_pll[0], pll_locked_i};
			m_lines <= {dev_rst1_i, dev_rst0_i};
			m_core <= core_rst_i;
			evt_hist <= {evt_hist[0], !(sd_di_i && sd_do_i) || dram_err_i};
			if (m_core || m_lines[1])
				m_sys_cnt <= 4095;
			else if (m_sys_cnt > 0)
				m_sys_cnt <= m_sys_cnt - 1;
			if (m_lines == 2'b01)
				m_pwr <= 1'b1;
			if (m_lines == 2'b11)
				m_ram_cnt <= 4095;
			else if (m_pll[1] && m_ram_cnt > 0)
				m_ram_cnt <= m_ram_cnt - 1;
			m_sys <= !m_pll[1] || m_pwr || (m_sys_cnt != 0);
			m_ram <= (m_ram_cnt != 0);
			m_act <= (m_dark == 0) && evt_hist[0];
			if (m_dark > 0)
				m_dark <= m_dark - 1;
			else if (evt_hist[0])
				m_dark <= 127;
		end
	end

	// Mid-cycle comparison, all outputs are settled here.
	always @(negedge clk100mhz_i) begin
		if (check_on) begin
			assert (sys_rst_o == m_sys)
				else report_error($sformatf("sys_rst_o is %b, expected %b", sys_rst_o, m_sys));
			assert (ram_rst_o == m_ram)
				else report_error($sformatf("ram_rst_o is %b, expected %b", ram_rst_o, m_ram));
			assert (activity_o == m_act)
				else report_error($sformatf("activity_o is %b, expected %b", activity_o, m_act));
			since_pulse++;
			if (activity_o) begin
				assert (evt_hist[1])
					else report_error("activity pulse without an event two cycles before");
				assert (since_pulse >= 128)
					else report_error($sformatf("activity pulses %0d cycles apart", since_pulse));
				since_pulse = 0;
				pulses++;
			end
		end
	end

	always @(posedge clk100mhz_i) begin
		cycles++;
		if (cycles > CYCLE_LIMIT) begin
			$display("Timeout: no verdict after %0d clock cycles", CYCLE_LIMIT);
			$display("*** FAILED ***");
			$finish;
		end
	end

	task automatic report_error(input string msg);
		$display("** Error at %0t ns: %s", $time, msg);
		errors++;
	endtask

	task automatic step(input int n);
		repeat (n) @(posedge clk100mhz_i);
		#1;
	endtask

	function automatic int rand_below(input int n);
		return $unsigned($random(seed)) % n;
	endfunction

	function automatic bit in_window(input int n);
		return (n >= 4095) && (n <= 4099);
	endfunction

	task automatic idle_inputs();
		{dev_rst1_i, dev_rst0_i, core_rst_i, dram_err_i} = 4'b0000;
		{pll_locked_i, sd_di_i, sd_do_i} = 3'b111;
	endtask

	task automatic apply_reset();
		rst_p = 1'b1;
		step(1);
		check_on = 1'b1;
		step(9);
		rst_p = 1'b0;
	endtask

	// Kinds are warm, core, cold and power-off.
	task automatic set_request(input int kind, input logic on);
		case (kind)
			0: dev_rst1_i = on;
			1: core_rst_i = on;
			2: {dev_rst1_i, dev_rst0_i} = {on, on};
			default: dev_rst0_i = on;
		endcase
	endtask

	// Cycles until each reset output is low, 0 when already low.
	task automatic wait_release(output int sys_n, output int ram_n);
		int n;
		n = 0;
		sys_n = sys_rst_o ? -1 : 0;
		ram_n = ram_rst_o ? -1 : 0;
		while ((sys_n < 0 || ram_n < 0) && n < 5000) begin
			step(1);
			n++;
			if (!sys_rst_o && sys_n < 0)
				sys_n = n;
			if (!ram_rst_o && ram_n < 0)
				ram_n = n;
		end
		if (sys_n < 0 || ram_n < 0) begin
			$display("Reset outputs were still high %0d cycles after the last hold", n);
			errors++;
		end
	endtask

	task automatic run_request(input int kind, input int len);
		int n;
		int i;
		int rise;
		int ram_rise;
		int sys_n;
		int ram_n;
		n = (len > 3) ? len : 3;
		rise = 0;
		ram_rise = 0;
		set_request(kind, 1'b1);
		for (i = 1; i <= n; i++) begin
			step(1);
			if (i == len)
				set_request(kind, 1'b0);
			if (sys_rst_o && rise == 0)
				rise = i;
			if (ram_rst_o && ram_rise == 0)
				ram_rise = i;
		end
		wait_release(sys_n, ram_n);
		assert (rise > 0 && rise <= 3)
			else report_error($sformatf("sys_rst_o rose %0d cycles after request", rise));
		assert (in_window(sys_n + n - len))
			else report_error($sformatf("sys_rst_o fell %0d cycles late", sys_n + n - len));
		if (kind == 2) begin
			assert (ram_rise > 0 && ram_rise <= 3 && in_window(ram_n + n - len))
				else report_error("ram_rst_o missed its window after a cold request");
		end else begin
			assert (ram_rise == 0 && ram_n == 0)
				else report_error("ram_rst_o rose on a warm or core request");
		end
	endtask

	task automatic finish_test(input string name);
		tests++;
		if (errors == test_start)
			$display("Test %0d, %s: ok", tests, name);
		else
			$display("Test %0d, %s: %0d errors", tests, name, errors - test_start);
		test_start = errors;
	endtask

	initial begin
		int i;
		int len;
		int rise;
		int last;
		int sys_n;
		int ram_n;
		seed = 32'h4d7b_f55b;
		check_on = 1'b0;
		since_pulse = 1000;
		{pulses, cycles, errors, tests, test_start} = '0;
		idle_inputs();
		apply_reset();
		assert (sys_rst_o && ram_rst_o && !activity_o)
			else report_error("outputs not at their reset values after rst_p");
		wait_release(sys_n, ram_n);
		assert (in_window(sys_n) && in_window(ram_n))
			else report_error($sformatf("resets fell after %0d and %0d cycles", sys_n, ram_n));
		finish_test("release after board reset");

		for (i = 0; i < 4; i++)
			run_request(i % 2, 1 + rand_below(24));
		finish_test("warm and core requests");
		for (i = 0; i < 2; i++)
			run_request(2, 1 + rand_below(24));
		finish_test("cold requests");

		set_request(3, 1'b1);
		step(2);
		set_request(3, 1'b0);
		len = 5000 + rand_below(3000);
		for (i = 1; i <= len; i++) begin
			{dev_rst1_i, dev_rst0_i, core_rst_i, sd_di_i, sd_do_i} = 5'($random(seed));
			dram_err_i = (rand_below(64) == 0);
			step(1);
			assert (sys_rst_o) else report_error("sys_rst_o fell while powered off");
		end
		idle_inputs();
		apply_reset();
		wait_release(sys_n, ram_n);
		assert (in_window(sys_n) && in_window(ram_n))
			else report_error("resets missed their window after a power-off");
		finish_test("power-off latch");

		len = 20 + rand_below(100);
		rise = 0;
		pll_locked_i = 1'b0;
		for (i = 1; i <= len; i++) begin
			step(1);
			if (sys_rst_o && rise == 0)
				rise = i;
			if (i >= 4) begin
				assert (sys_rst_o) else report_error("sys_rst_o low while the PLL is unlocked");
			end
		end
		assert (rise > 0 && rise <= 4)
			else report_error($sformatf("sys_rst_o rose %0d cycles after lock loss", rise));
		pll_locked_i = 1'b1;
		step(8);
		finish_test("PLL lock loss");

		last = pulses;
		for (i = 0; i < 4000; i++) begin
			sd_di_i = (rand_below(16) != 0);
			sd_do_i = (rand_below(16) != 0);
			dram_err_i = (rand_below(64) == 0);
			step(1);
		end
		assert (pulses - last >= 20)
			else report_error($sformatf("only %0d pulses on random traffic", pulses - last));
		// Continuous traffic.
		{sd_di_i, sd_do_i, dram_err_i} = 3'b010;
		last = 0;
		len = 0;
		for (i = 1; i <= 1200; i++) begin
			step(1);
			if (activity_o) begin
				if (last > 0) begin
					assert (i - last == 128)
						else report_error($sformatf("pulse interval %0d, expected 128", i - last));
				end
				last = i;
				len++;
			end
		end
		assert (len >= 9) else report_error($sformatf("only %0d pulses on steady traffic", len));
		idle_inputs();
		step(4);
		finish_test("activity pulses");

		$display("%0d tests run, %0d errors", tests, errors);
		if (errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

//--- test/board_rst_chk.sv
// Assertions on the reset sequencer and the activity dimmer.
// Bound into both modules. Ports that a module has no signal for are tied
// off, which leaves the assertions about the other module vacuous there.

`timescale 1ns/1ps

module board_rst_chk (
	 input  logic clk100mhz_i
	,input  logic rst_p
	,input  logic hold_i
	,input  board_pkg::sw_rst_cmd_t sw_cmd_i
	,input  logic sys_rst_i
	,input  logic pulse_i
);

	logic hold_q;
	logic pwr_seen_q;
	board_pkg::act_cnt_t gap_q;

	// The counter reloads on the hold itself, the output follows a cycle later.
	always_ff @(posedge clk100mhz_i) begin
		if (rst_p) begin
			hold_q <= 1'b0;
			gap_q <= '0;
		end else begin
			hold_q <= hold_i;
			if (pulse_i) begin
				gap_q <= '1;
			end else if (gap_q != '0) begin
				gap_q <= gap_q - 1'b1;
			end
		end
	end

	// Power-off command seen since the last board reset.
	always_ff @(posedge clk100mhz_i) begin
		if (rst_p) begin
			pwr_seen_q <= 1'b0;
		end else if (sw_cmd_i == board_pkg::SW_RST_POWEROFF) begin
			pwr_seen_q <= 1'b1;
		end
	end

	pwr_off_holds_reset: assert property (@(posedge clk100mhz_i) disable iff (rst_p)
		pwr_seen_q |=> sys_rst_i)
		else $error("sys_rst_o low after a power-off command");

	hold_raises_reset: assert property (@(posedge clk100mhz_i) disable iff (rst_p)
		hold_q |=> sys_rst_i)
		else $error("sys_rst_o not raised after a reset hold");

	// Dark interval of 127 cycles after each pulse.
	pulse_spacing: assert property (@(posedge clk100mhz_i) disable iff (rst_p)
		pulse_i |-> (gap_q == '0))
		else $error("activity pulse inside the dark interval");

endmodule

bind reset_sequencer board_rst_chk u_chk (
	 .clk100mhz_i (clk100mhz_i)
	,.rst_p       (rst_p)
	,.hold_i      (sys_hold)
	,.sw_cmd_i    (evt.sw_cmd)
	,.sys_rst_i   (sys_rst_o)
	,.pulse_i     (1'b0)
);

bind activity_dimmer board_rst_chk u_chk (
	 .clk100mhz_i (clk100mhz_i)
	,.rst_p       (rst_p)
	,.hold_i      (1'b0)
	,.sw_cmd_i    (board_pkg::SW_RST_NONE)
	,.sys_rst_i   (1'b1)
	,.pulse_i     (activity_o)
);

//--- source/board_rst_top.sv
// Top level of the board reset and activity logic.
// Board-level inputs come in as plain ports, are registered by the input
// stage and shared over the event interface with the reset sequencer and
// the activity dimmer.

`timescale 1ns/1ps

module board_rst_top (
	 input  logic clk100mhz_i
	,input  logic rst_p
	,input  logic pll_locked_i
	,input  logic dev_rst0_i
	,input  logic dev_rst1_i
	,input  logic core_rst_i
	,input  logic sd_di_i
	,input  logic sd_do_i
	,input  logic dram_err_i
	,output logic sys_rst_o
	,output logic ram_rst_o
	,output logic activity_o
);

	board_evt_if evt_bus ();

	board_in_sync u_in (
		 .clk100mhz_i  (clk100mhz_i)
		,.rst_p        (rst_p)
		,.pll_locked_i (pll_locked_i)
		,.dev_rst0_i   (dev_rst0_i)
		,.dev_rst1_i   (dev_rst1_i)
		,.core_rst_i   (core_rst_i)
		,.sd_di_i      (sd_di_i)
		,.sd_do_i      (sd_do_i)
		,.dram_err_i   (dram_err_i)
		,.evt          (evt_bus.src)
	);

	reset_sequencer u_seq (
		 .clk100mhz_i (clk100mhz_i)
		,.rst_p       (rst_p)
		,.evt         (evt_bus.seq)
		,.sys_rst_o   (sys_rst_o)
		,.ram_rst_o   (ram_rst_o)
	);

	// Indicator for SD traffic and DRAM init errors.
	activity_dimmer u_act (
		 .clk100mhz_i (clk100mhz_i)
		,.rst_p       (rst_p)
		,.evt         (evt_bus.act)
		,.activity_o  (activity_o)
	);

endmodule

//--- source/activity_dimmer.sv
// Activity indicator driver.
// Turns activity events into single-cycle pulses followed by a fixed
// dark interval, so the LED stays dim under continuous traffic.

`timescale 1ns/1ps

module activity_dimmer (
	 input  logic clk100mhz_i
	,input  logic rst_p
	,board_evt_if.act evt
	,output logic activity_o
);

	board_pkg::act_cnt_t dark_cnt;

	always_ff @(posedge clk100mhz_i) begin
		if (rst_p) begin
			dark_cnt <= '0;
			activity_o <= 1'b0;
		end else if (dark_cnt != '0) begin
			// Dark interval, events are ignored.
			dark_cnt <= dark_cnt - 1'b1;
			activity_o <= 1'b0;
		end else if (evt.act_evt) begin
			// One pulse, then a full dark interval.
			dark_cnt <= '1;
			activity_o <= 1'b1;
		end else begin
			activity_o <= 1'b0;
		end
	end

endmodule

//--- source/reset_sequencer.sv
// Reset sequencer for the board.
// Holds the system in reset for a full counter window after a board reset,
// a core request or a warm or cold command, and while the PLL is unlocked.
// A power-off command latches the system in reset until the next board
// reset. The memory reset runs its own window, restarted only by a board
// reset or a cold command.

`timescale 1ns/1ps

module reset_sequencer (
	 input  logic clk100mhz_i
	,input  logic rst_p
	,board_evt_if.seq evt
	,output logic sys_rst_o
	,output logic ram_rst_o
);

	board_pkg::rst_cnt_t sys_cnt;
	board_pkg::rst_cnt_t ram_cnt;
	logic pwr_off_q;
	logic sys_hold;
	logic cold_cmd;

	assign cold_cmd = (evt.sw_cmd == board_pkg::SW_RST_COLD);

	// Any request that restarts the system window.
	assign sys_hold = evt.core_hold || cold_cmd ||
		(evt.sw_cmd == board_pkg::SW_RST_WARM);

	// System window.
	// Reloads on every cycle a request is present, so the window
	// starts from the last one.
	always_ff @(posedge clk100mhz_i) begin
		if (rst_p || sys_hold) begin
			sys_cnt <= '1;
		end else if (sys_cnt != '0) begin
			sys_cnt <= sys_cnt - 1'b1;
		end
	end

	// Power-off latch.
	// Only a board reset brings the system back.
	always_ff @(posedge clk100mhz_i) begin
		if (rst_p) begin
			pwr_off_q <= 1'b0;
		end else if (evt.sw_cmd == board_pkg::SW_RST_POWEROFF) begin
			pwr_off_q <= 1'b1;
		end
	end

	// Memory window.
	// Warm resets and core requests leave the DRAM contents alone,
	// and the window only advances once the clocks are stable.
	always_ff @(posedge clk100mhz_i) begin
		if (rst_p || cold_cmd) begin
			ram_cnt <= '1;
		end else if (evt.pll_ok && (ram_cnt != '0)) begin
			ram_cnt <= ram_cnt - 1'b1;
		end
	end

	always_ff @(posedge clk100mhz_i) begin
		if (rst_p) begin
			sys_rst_o <= 1'b1;
			ram_rst_o <= 1'b1;
		end else begin
			sys_rst_o <= !evt.pll_ok || pwr_off_q || (sys_cnt != '0);
			ram_rst_o <= (ram_cnt != '0);
		end
	end

endmodule

//--- source/board_in_sync.sv
// Input stage of the board reset logic.
// Synchronizes PLL lock, registers the raw request lines and decodes the
// device-table reset lines into a command. All outputs go onto the event
// interface one cycle after sampling, PLL lock after the synchronizer.

`timescale 1ns/1ps
`include "board_defines.svh"

module board_in_sync (
	 input  logic clk100mhz_i
	,input  logic rst_p
	,input  logic pll_locked_i
	,input  logic dev_rst0_i
	,input  logic dev_rst1_i
	,input  logic core_rst_i
	,input  logic sd_di_i
	,input  logic sd_do_i
	,input  logic dram_err_i
	,board_evt_if.src evt
);

	logic [`SYNC_STAGES-1:0] pll_sync;
	board_pkg::sw_rst_cmd_t sw_cmd_d;
	logic act_evt_d;

	// Both lines high is a cold reset, line 1 alone a warm reset,
	// line 0 alone a power-off.
	always_comb begin
		case ({dev_rst1_i, dev_rst0_i})
			2'b11: sw_cmd_d = board_pkg::SW_RST_COLD;
			2'b10: sw_cmd_d = board_pkg::SW_RST_WARM;
			2'b01: sw_cmd_d = board_pkg::SW_RST_POWEROFF;
			default: sw_cmd_d = board_pkg::SW_RST_NONE;
		endcase
	end

	// The SD lines idle high, so any low level is bus traffic.
	assign act_evt_d = !(sd_di_i && sd_do_i) || dram_err_i;

	always_ff @(posedge clk100mhz_i) begin
		if (rst_p) begin
			pll_sync <= '0;
			evt.sw_cmd <= board_pkg::SW_RST_NONE;
			evt.core_hold <= 1'b0;
			evt.act_evt <= 1'b0;
		end else begin
			pll_sync <= {pll_sync[`SYNC_STAGES-2:0], pll_locked_i};
			evt.sw_cmd <= sw_cmd_d;
			evt.core_hold <= core_rst_i;
			evt.act_evt <= act_evt_d;
		end
	end

	// Last synchronizer stage.
	assign evt.pll_ok = pll_sync[`SYNC_STAGES-1];

endmodule

//--- source/board_evt_if.sv
// Registered board events from the input stage.
// The input stage drives all signals, the sequencer and the activity
// dimmer each read their own subset. Every signal is a plain level.

`timescale 1ns/1ps

interface board_evt_if;

	// Synchronized PLL lock.
	logic pll_ok;
	// Decoded software reset command.
	board_pkg::sw_rst_cmd_t sw_cmd;
	// Processor core reset request.
	logic core_hold;
	// SD bus traffic or DRAM init error.
	logic act_evt;

	modport src (output pll_ok, output sw_cmd, output core_hold, output act_evt);

	modport seq (input pll_ok, input sw_cmd, input core_hold);

	modport act (input act_evt);

endinterface

//--- source/board_pkg.sv
// Types shared by the board reset and activity logic.
// Referenced by scoped names from every RTL file that needs them.

package board_pkg;

	`include "board_defines.svh"

	// Software reset command decoded from the two device-table lines.
	// Encoding follows {rst1, rst0}.
	typedef enum logic [1:0] {
		SW_RST_NONE     = 2'b00,
		SW_RST_POWEROFF = 2'b01,
		SW_RST_WARM     = 2'b10,
		SW_RST_COLD     = 2'b11
	} sw_rst_cmd_t;

	// Down-counter for the system and memory reset holds.
	typedef logic [`RST_CNT_W-1:0] rst_cnt_t;

	// Down-counter for the activity dark interval.
	typedef logic [`ACT_CNT_W-1:0] act_cnt_t;

endpackage

//--- include/board_defines.svh
// Fixed sizes for the board reset and activity logic.
// Included by the package and by any RTL file that needs a raw width.
// Widths are chosen for this board and are not overridden per instance.

`ifndef BOARD_DEFINES_SVH
`define BOARD_DEFINES_SVH

// Width of the system and memory reset counters.
// All ones gives 4095 cycles of hold after the last request.
`define RST_CNT_W 12

// Width of the activity dark-interval counter.
// A full load gives 127 dark cycles between pulses.
`define ACT_CNT_W 7

// Flip-flops on the PLL lock synchronizer.
// The lock comes from another clock domain on the board.
`define SYNC_STAGES 2

`endif
